/* logic/out_sram_pkg.sv */
package out_sram_pkg;

    localparam int num_edge_pe = 2;
    localparam int num_vertex_unit = 2;
    localparam int num_reqs = num_edge_pe + num_vertex_unit; // Edge PEs first, then vertex units.
    localparam int num_banks = 4;
    localparam int bank_bits = 2;
    localparam int node_bits = 8;
    localparam int data_bits = 16;
    localparam int rec_words = 4;
    localparam int word_bits = 2;
    localparam int tag_bits = 1;
    localparam int bank_rows = 64;

    // The same 18 bits carry either the read tag or a write word with its stream marks.
    typedef union packed {
        struct packed {
            logic [tag_bits-1:0] tag;
            logic [data_bits-tag_bits+1:0] pad;
        } rd;
        struct packed {
            logic [data_bits-1:0] data;
            logic sos;
            logic eos;
        } wr;
    } bank_payload_t;

    typedef struct packed {
        logic valid;
        logic rd_wr; // 1 is a write.
        logic [node_bits-1:0] node;
        logic [word_bits-1:0] word;
        bank_payload_t payload;
    } bank_req_t;

endpackage

/* logic/arb_req_if.sv */
interface arb_req_if #(
    parameter int n = 2
);

    logic [n-1:0] req;
    logic [n-1:0][out_sram_pkg::node_bits-1:0] node;
    logic [n-1:0] grant; // Combinational, one-hot or zero.

    // Write group only. The first word rides on the grant cycle.
    logic [n-1:0] wr_valid;
    logic [n-1:0][out_sram_pkg::data_bits-1:0] wr_data;
    logic [n-1:0][out_sram_pkg::word_bits-1:0] wr_word;
    logic [n-1:0] wr_eos;

    modport port_side (
        output req, node, wr_valid, wr_data, wr_word, wr_eos,
        input  grant
    );

    modport arb_side (
        input  req, node, wr_valid, wr_data, wr_word, wr_eos,
        output grant
    );

endinterface

/* logic/rr_arbiter.sv */
module rr_arbiter #(
    parameter int num_reqs = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic [num_reqs-1:0] reqs,
    output logic [num_reqs-1:0] grants
);

    logic [$clog2(num_reqs)-1:0] ptr;
    logic [$clog2(num_reqs)-1:0] winner;
    logic found;
    int idx;

    // Search starts at the pointer and wraps around.
    always_comb begin
        grants = '0;
        found = 1'b0;
        winner = ptr;
        idx = 0;
        for (int k = 0; k < num_reqs; k++) begin
            idx = (int'(ptr) + k) % num_reqs;
            if (!found && reqs[idx]) begin
                grants[idx] = 1'b1;
                winner = idx[$clog2(num_reqs)-1:0];
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= (int'(winner) == num_reqs - 1) ? '0 : winner + 1'b1; // Winner drops to last.
        end
    end

    a_grant_legal: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grants) && ((grants & ~reqs) == '0)
    ) else $error("rr_arbiter granted an idle or second requester");

endmodule

/* logic/edge_read_port.sv */
module edge_read_port (
    input  logic clk,
    input  logic reset,
    input  logic [out_sram_pkg::num_edge_pe-1:0] edge_req_valid,
    input  logic [out_sram_pkg::num_edge_pe-1:0][out_sram_pkg::node_bits-1:0] edge_req_node,
    output logic [out_sram_pkg::num_edge_pe-1:0] edge_req_accept,
    output logic [out_sram_pkg::num_edge_pe-1:0] edge_resp_valid,
    output logic [out_sram_pkg::num_edge_pe-1:0][out_sram_pkg::data_bits-1:0] edge_resp_data,
    output logic [out_sram_pkg::num_edge_pe-1:0] edge_resp_last,
    arb_req_if.port_side bus,
    input  logic [out_sram_pkg::num_banks-1:0] resp_valid,
    input  logic [out_sram_pkg::num_banks-1:0][out_sram_pkg::data_bits-1:0] resp_data,
    input  logic [out_sram_pkg::num_banks-1:0][out_sram_pkg::tag_bits-1:0] resp_tag,
    input  logic [out_sram_pkg::num_banks-1:0] resp_last
);

    logic [out_sram_pkg::num_edge_pe-1:0] pending;
    logic [out_sram_pkg::num_edge_pe-1:0] granted;
    logic [out_sram_pkg::num_edge_pe-1:0][out_sram_pkg::node_bits-1:0] node_q;

    assign edge_req_accept = edge_req_valid & ~pending;
    assign bus.req = pending & ~granted; // Held until the arbiter answers.
    assign bus.node = node_q;
    assign bus.wr_valid = '0;
    assign bus.wr_data = '0;
    assign bus.wr_word = '0;
    assign bus.wr_eos = '0;

    // A PE has at most one read in flight, so only one bank can answer it at a time.
    always_comb begin
        edge_resp_valid = '0;
        edge_resp_data = '0;
        edge_resp_last = '0;
        for (int b = 0; b < out_sram_pkg::num_banks; b++) begin
            if (resp_valid[b]) begin
                edge_resp_valid[resp_tag[b]] = 1'b1;
                edge_resp_data[resp_tag[b]] = resp_data[b];
                edge_resp_last[resp_tag[b]] = resp_last[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            granted <= '0;
        end else begin
            for (int p = 0; p < out_sram_pkg::num_edge_pe; p++) begin
                if (edge_req_accept[p]) begin
                    pending[p] <= 1'b1;
                    granted[p] <= 1'b0;
                end else begin
                    if (bus.grant[p]) granted[p] <= 1'b1;
                    if (edge_resp_last[p]) pending[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < out_sram_pkg::num_edge_pe; p++) begin
            if (edge_req_accept[p]) node_q[p] <= edge_req_node[p];
        end
    end

    for (genvar b = 0; b < out_sram_pkg::num_banks; b++) begin : g_chk
        a_resp_owned: assert property (
            @(posedge clk) disable iff (reset)
            resp_valid[b] |-> pending[resp_tag[b]] && granted[resp_tag[b]]
        ) else $error("bank %0d answered a PE with no read in flight", b);
    end

endmodule

/* logic/vertex_write_port.sv */
module vertex_write_port (
    input  logic clk,
    input  logic reset,
    input  logic [out_sram_pkg::num_vertex_unit-1:0] vertex_wr_valid,
    input  logic [out_sram_pkg::num_vertex_unit-1:0][out_sram_pkg::node_bits-1:0] vertex_wr_node,
    input  logic [out_sram_pkg::num_vertex_unit-1:0][out_sram_pkg::data_bits-1:0] vertex_wr_data,
    input  logic [out_sram_pkg::num_vertex_unit-1:0] vertex_wr_last,
    output logic [out_sram_pkg::num_vertex_unit-1:0] vertex_wr_ready,
    arb_req_if.port_side bus
);

    logic [out_sram_pkg::num_vertex_unit-1:0] owned;
    logic [out_sram_pkg::num_vertex_unit-1:0][out_sram_pkg::word_bits-1:0] count;
    logic [out_sram_pkg::num_vertex_unit-1:0][out_sram_pkg::node_bits-1:0] node_q;

    always_comb begin
        for (int u = 0; u < out_sram_pkg::num_vertex_unit; u++) begin
            bus.req[u] = vertex_wr_valid[u] && !owned[u]; // Only the first word arbitrates.
            bus.node[u] = owned[u] ? node_q[u] : vertex_wr_node[u];
            bus.wr_valid[u] = owned[u] && vertex_wr_valid[u];
            bus.wr_data[u] = vertex_wr_data[u];
            bus.wr_word[u] = owned[u] ? count[u] : '0;
            bus.wr_eos[u] = vertex_wr_last[u];
            vertex_wr_ready[u] = bus.grant[u] || owned[u];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            owned <= '0;
            count <= '0;
        end else begin
            for (int u = 0; u < out_sram_pkg::num_vertex_unit; u++) begin
                if (bus.grant[u]) begin
                    owned[u] <= !vertex_wr_last[u]; // A one-word burst never holds the bank.
                    count[u] <= 'd1;
                end else if (bus.wr_valid[u]) begin
                    count[u] <= count[u] + 1'b1;
                    if (vertex_wr_last[u]) owned[u] <= 1'b0;
                end
            end
        end
    end

    // The bank stays locked, so its index must not move mid-burst.
    always_ff @(posedge clk) begin
        for (int u = 0; u < out_sram_pkg::num_vertex_unit; u++) begin
            if (bus.grant[u]) node_q[u] <= vertex_wr_node[u];
        end
    end

    for (genvar u = 0; u < out_sram_pkg::num_vertex_unit; u++) begin : g_chk
        a_burst_len: assert property (
            @(posedge clk) disable iff (reset)
            owned[u] && vertex_wr_valid[u]
                && count[u] == out_sram_pkg::word_bits'(out_sram_pkg::rec_words - 1)
            |-> vertex_wr_last[u]
        ) else $error("vertex unit %0d burst runs past one record", u);
    end

endmodule

/* logic/output_bus_arbiter.sv */
module output_bus_arbiter (
    input  logic clk,
    input  logic reset,
    arb_req_if.arb_side edge_bus,
    arb_req_if.arb_side vertex_bus,
    output out_sram_pkg::bank_req_t [out_sram_pkg::num_banks-1:0] bank_req,
    input  logic [out_sram_pkg::num_banks-1:0] resp_last
);

    logic [out_sram_pkg::num_reqs-1:0] reqs;
    logic [out_sram_pkg::num_reqs-1:0] masked_reqs;
    logic [out_sram_pkg::num_reqs-1:0] grants;
    logic [out_sram_pkg::num_reqs-1:0][out_sram_pkg::bank_bits-1:0] target;
    logic [out_sram_pkg::num_banks-1:0] busy, busy_nx;
    logic [out_sram_pkg::num_banks-1:0][out_sram_pkg::num_reqs-1:0] owner, owner_nx;
    out_sram_pkg::bank_req_t [out_sram_pkg::num_banks-1:0] req_nx;

    function automatic out_sram_pkg::bank_req_t wr_req(
        input logic [out_sram_pkg::node_bits-1:0] node,
        input logic [out_sram_pkg::word_bits-1:0] word,
        input logic [out_sram_pkg::data_bits-1:0] data,
        input logic sos,
        input logic eos
    );
        out_sram_pkg::bank_req_t r;
        r = '0;
        r.valid = 1'b1;
        r.rd_wr = 1'b1;
        r.node = node;
        r.word = word;
        r.payload.wr.data = data;
        r.payload.wr.sos = sos;
        r.payload.wr.eos = eos;
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < out_sram_pkg::num_edge_pe; i++) begin
            reqs[i] = edge_bus.req[i];
            target[i] = edge_bus.node[i][out_sram_pkg::bank_bits-1:0];
        end
        for (int u = 0; u < out_sram_pkg::num_vertex_unit; u++) begin
            reqs[out_sram_pkg::num_edge_pe+u] = vertex_bus.req[u];
            target[out_sram_pkg::num_edge_pe+u] = vertex_bus.node[u][out_sram_pkg::bank_bits-1:0];
        end
        for (int i = 0; i < out_sram_pkg::num_reqs; i++) begin
            masked_reqs[i] = reqs[i] && !busy[target[i]]; // Locked banks take no new stream.
        end
    end

    rr_arbiter #(
        .num_reqs(out_sram_pkg::num_reqs)
    ) u_rr_arbiter (
        .clk(clk),
        .reset(reset),
        .reqs(masked_reqs),
        .grants(grants)
    );

    assign edge_bus.grant = grants[out_sram_pkg::num_edge_pe-1:0];
    assign vertex_bus.grant = grants[out_sram_pkg::num_reqs-1:out_sram_pkg::num_edge_pe];

    always_comb begin
        busy_nx = busy;
        owner_nx = owner;
        req_nx = '0;
        for (int i = 0; i < out_sram_pkg::num_reqs; i++) begin
            if (grants[i]) begin
                busy_nx[target[i]] = 1'b1;
                owner_nx[target[i]] = grants;
            end
        end
        for (int e = 0; e < out_sram_pkg::num_edge_pe; e++) begin
            if (grants[e]) begin
                req_nx[target[e]].valid = 1'b1;
                req_nx[target[e]].node = edge_bus.node[e];
                req_nx[target[e]].payload.rd.tag = out_sram_pkg::tag_bits'(e);
            end
        end
        for (int u = 0; u < out_sram_pkg::num_vertex_unit; u++) begin
            if (grants[out_sram_pkg::num_edge_pe+u]) begin
                req_nx[target[out_sram_pkg::num_edge_pe+u]] = wr_req(vertex_bus.node[u],
                    vertex_bus.wr_word[u], vertex_bus.wr_data[u], 1'b1, vertex_bus.wr_eos[u]);
                if (vertex_bus.wr_eos[u]) busy_nx[target[out_sram_pkg::num_edge_pe+u]] = 1'b0;
            end
        end
        // Later words go to the bank their unit already owns.
        for (int b = 0; b < out_sram_pkg::num_banks; b++) begin
            for (int u = 0; u < out_sram_pkg::num_vertex_unit; u++) begin
                if (busy[b] && owner[b][out_sram_pkg::num_edge_pe+u] && vertex_bus.wr_valid[u]) begin
                    req_nx[b] = wr_req(vertex_bus.node[u], vertex_bus.wr_word[u],
                        vertex_bus.wr_data[u], 1'b0, vertex_bus.wr_eos[u]);
                    if (vertex_bus.wr_eos[u]) busy_nx[b] = 1'b0;
                end
            end
            if (resp_last[b]) busy_nx[b] = 1'b0; // Read stream done.
        end
    end

    always_ff @(posedge clk) begin
        bank_req <= req_nx;
        owner <= owner_nx;
        if (reset) begin
            busy <= '0;
            for (int b = 0; b < out_sram_pkg::num_banks; b++) begin
                bank_req[b].valid <= 1'b0;
            end
        end else begin
            busy <= busy_nx;
        end
    end

    for (genvar i = 0; i < out_sram_pkg::num_reqs; i++) begin : g_chk
        a_bank_free: assert property (
            @(posedge clk) disable iff (reset)
            grants[i] |-> !busy[target[i]]
        ) else $error("requester %0d granted a locked bank", i);
    end

endmodule

/* logic/output_sram_bank.sv */
module output_sram_bank (
    input  logic clk,
    input  logic reset,
    input  out_sram_pkg::bank_req_t bank_req,
    output logic resp_valid,
    output logic [out_sram_pkg::data_bits-1:0] resp_data,
    output logic [out_sram_pkg::tag_bits-1:0] resp_tag,
    output logic resp_last
);

    logic [out_sram_pkg::data_bits-1:0] mem [out_sram_pkg::bank_rows][out_sram_pkg::rec_words];
    logic [out_sram_pkg::node_bits-out_sram_pkg::bank_bits-1:0] row;
    logic [out_sram_pkg::node_bits-out_sram_pkg::bank_bits-1:0] rd_row;
    logic [out_sram_pkg::word_bits-1:0] rd_word;
    logic active; // Words 1 to 3 of a read are still to come.

    assign row = bank_req.node[out_sram_pkg::node_bits-1:out_sram_pkg::bank_bits];

    always_ff @(posedge clk) begin
        if (bank_req.valid && bank_req.rd_wr) begin
            mem[row][bank_req.word] <= bank_req.payload.wr.data;
        end
    end

    // Word 0 leaves in the cycle after the request so the stream has no bubble.
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            resp_valid <= 1'b0;
            resp_last <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            resp_last <= 1'b0;
            if (bank_req.valid && !bank_req.rd_wr) begin
                active <= 1'b1;
                resp_valid <= 1'b1;
                rd_row <= row;
                rd_word <= 'd1;
                resp_tag <= bank_req.payload.rd.tag;
                resp_data <= mem[row][0];
            end else if (active) begin
                resp_valid <= 1'b1;
                resp_data <= mem[rd_row][rd_word];
                rd_word <= rd_word + 1'b1;
                if (rd_word == out_sram_pkg::word_bits'(out_sram_pkg::rec_words - 1)) begin
                    resp_last <= 1'b1;
                    active <= 1'b0;
                end
            end
        end
    end

    a_no_overlap: assert property (
        @(posedge clk) disable iff (reset)
        bank_req.valid |-> !active
    ) else $error("bank request arrived during a read stream");

endmodule

/* logic/output_sram_subsystem.sv */
module output_sram_subsystem (
    input  logic clk,
    input  logic reset,
    input  logic [out_sram_pkg::num_edge_pe-1:0] edge_req_valid,
    input  logic [out_sram_pkg::num_edge_pe-1:0][out_sram_pkg::node_bits-1:0] edge_req_node,
    output logic [out_sram_pkg::num_edge_pe-1:0] edge_req_accept,
    output logic [out_sram_pkg::num_edge_pe-1:0] edge_resp_valid,
    output logic [out_sram_pkg::num_edge_pe-1:0][out_sram_pkg::data_bits-1:0] edge_resp_data,
    output logic [out_sram_pkg::num_edge_pe-1:0] edge_resp_last,
    input  logic [out_sram_pkg::num_vertex_unit-1:0] vertex_wr_valid,
    input  logic [out_sram_pkg::num_vertex_unit-1:0][out_sram_pkg::node_bits-1:0] vertex_wr_node,
    input  logic [out_sram_pkg::num_vertex_unit-1:0][out_sram_pkg::data_bits-1:0] vertex_wr_data,
    input  logic [out_sram_pkg::num_vertex_unit-1:0] vertex_wr_last,
    output logic [out_sram_pkg::num_vertex_unit-1:0] vertex_wr_ready
);

    arb_req_if #(.n(out_sram_pkg::num_edge_pe)) edge_bus ();
    arb_req_if #(.n(out_sram_pkg::num_vertex_unit)) vertex_bus ();

    out_sram_pkg::bank_req_t [out_sram_pkg::num_banks-1:0] bank_req;
    logic [out_sram_pkg::num_banks-1:0] resp_valid;
    logic [out_sram_pkg::num_banks-1:0][out_sram_pkg::data_bits-1:0] resp_data;
    logic [out_sram_pkg::num_banks-1:0][out_sram_pkg::tag_bits-1:0] resp_tag;
    logic [out_sram_pkg::num_banks-1:0] resp_last;

    edge_read_port u_edge_read_port (
        .clk(clk),
        .reset(reset),
        .edge_req_valid(edge_req_valid),
        .edge_req_node(edge_req_node),
        .edge_req_accept(edge_req_accept),
        .edge_resp_valid(edge_resp_valid),
        .edge_resp_data(edge_resp_data),
        .edge_resp_last(edge_resp_last),
        .bus(edge_bus.port_side),
        .resp_valid(resp_valid),
        .resp_data(resp_data),
        .resp_tag(resp_tag),
        .resp_last(resp_last)
    );

    vertex_write_port u_vertex_write_port (
        .clk(clk),
        .reset(reset),
        .vertex_wr_valid(vertex_wr_valid),
        .vertex_wr_node(vertex_wr_node),
        .vertex_wr_data(vertex_wr_data),
        .vertex_wr_last(vertex_wr_last),
        .vertex_wr_ready(vertex_wr_ready),
        .bus(vertex_bus.port_side)
    );

    output_bus_arbiter u_output_bus_arbiter (
        .clk(clk),
        .reset(reset),
        .edge_bus(edge_bus.arb_side),
        .vertex_bus(vertex_bus.arb_side),
        .bank_req(bank_req),
        .resp_last(resp_last)
    );

    for (genvar b = 0; b < out_sram_pkg::num_banks; b++) begin : g_bank
        output_sram_bank u_bank (
            .clk(clk),
            .reset(reset),
            .bank_req(bank_req[b]),
            .resp_valid(resp_valid[b]),
            .resp_data(resp_data[b]),
            .resp_tag(resp_tag[b]),
            .resp_last(resp_last[b])
        );
    end

endmodule

/* tests/output_sram_model.sv */
package output_sram_model;

    logic [15:0] lfsr = 16'd3;
    logic [out_sram_pkg::data_bits-1:0] records
        [2**out_sram_pkg::node_bits][out_sram_pkg::rec_words];
    logic [out_sram_pkg::data_bits-1:0] expected_words [out_sram_pkg::num_edge_pe][$];

    // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1, stepped once per bit taken.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hb400 : lfsr >> 1;
        end
        return value;
    endfunction

    // A read sees the record as it stands when the PE's request is accepted.
    function automatic void expect_read(input int pe, input logic [7:0] node);
        for (int w = 0; w < out_sram_pkg::rec_words; w++) begin
            expected_words[pe].push_back(records[node][w]);
        end
    endfunction

endpackage

/* tests/output_sram_tb.sv */
module output_sram_tb;

    localparam int reset_cycles = 8;
    localparam int ops = 256 + 48 + 32 + 96 + 4 + 1; // Bursts and reads over all phases.

    logic clk, reset;
    logic [1:0] edge_req_valid, edge_req_accept, edge_resp_valid, edge_resp_last;
    logic [1:0][7:0] edge_req_node, vertex_wr_node;
    logic [1:0][15:0] edge_resp_data, vertex_wr_data;
    logic [1:0] vertex_wr_valid, vertex_wr_last, vertex_wr_ready;
    logic [7:0] node;
    int win;

    output_sram_subsystem u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #((reset_cycles + 20 * ops) * 10);
        stop_with_failure("The run timed out with operations still outstanding.");
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            stop_with_failure($sformatf("error %s expected %0h got %0h", name, want, got));
        end
    endtask

    task automatic write_burst(input int u, input logic [7:0] wr_node, input int len);
        logic [15:0] data;
        for (int w = 0; w < len; w++) begin
            data = output_sram_model::random_bits(16);
            vertex_wr_valid[u] = 1'b1;
            vertex_wr_node[u] = wr_node;
            vertex_wr_data[u] = data;
            vertex_wr_last[u] = (w == len - 1);
            @(negedge clk);
            while (!vertex_wr_ready[u]) @(negedge clk);
            output_sram_model::records[wr_node][w] = data; // Taken at the coming edge.
            @(posedge clk);
            #1;
        end
        vertex_wr_valid[u] = 1'b0;
        vertex_wr_last[u] = 1'b0;
    endtask

    task automatic read_node(input int p, input logic [7:0] rd_node);
        edge_req_valid[p] = 1'b1;
        edge_req_node[p] = rd_node;
        @(negedge clk);
        while (!edge_req_accept[p]) @(negedge clk);
        output_sram_model::expect_read(p, rd_node);
        @(posedge clk);
        #1;
        edge_req_valid[p] = 1'b0;
    endtask

    task automatic wait_idle();
        while (output_sram_model::expected_words[0].size() != 0
            || output_sram_model::expected_words[1].size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // Each PE has one read in flight, so its words come back in record order.
    always @(negedge clk) begin
        logic [15:0] want;
        for (int p = 0; p < 2; p++) begin
            if (!reset && edge_resp_valid[p]) begin
                if (output_sram_model::expected_words[p].size() == 0) begin
                    stop_with_failure($sformatf("PE %0d got a word it never asked for.", p));
                end else begin
                    want = output_sram_model::expected_words[p].pop_front();
                    compare_value($sformatf("edge_resp_data[%0d]", p), edge_resp_data[p], want);
                    compare_value($sformatf("edge_resp_last[%0d]", p), edge_resp_last[p],
                        output_sram_model::expected_words[p].size() == 0);
                end
            end
        end
    end

    initial begin
        reset = 1'b1;
        edge_req_valid = '0;
        edge_req_node = '0;
        vertex_wr_valid = '0;
        vertex_wr_node = '0;
        vertex_wr_data = '0;
        vertex_wr_last = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        compare_value("edge_req_accept", edge_req_accept, 0);
        compare_value("edge_resp_valid", edge_resp_valid, 0);
        compare_value("edge_resp_last", edge_resp_last, 0);
        compare_value("vertex_wr_ready", vertex_wr_ready, 0);
        @(posedge clk);
        #1;
        // Every node gets a full record first. Nodes i and 255 - i never share a bank.
        for (int i = 0; i < 128; i++) begin
            fork
                write_burst(0, i, 4);
                write_burst(1, 255 - i, 4);
            join
        end
        fork
            repeat (24) read_node(0, output_sram_model::random_bits(8));
            repeat (24) read_node(1, output_sram_model::random_bits(8));
        join
        wait_idle();
        repeat (16) begin
            node = output_sram_model::random_bits(8);
            write_burst(output_sram_model::random_bits(1), node,
                1 + output_sram_model::random_bits(2) % 3);
            read_node(output_sram_model::random_bits(1), node);
            wait_idle();
        end
        // Readers stay in the lower half of the node space, writers in the upper half.
        fork
            repeat (24) read_node(0, output_sram_model::random_bits(8) & 8'h7f);
            repeat (24) read_node(1, output_sram_model::random_bits(8) & 8'h7f);
            repeat (24) write_burst(0, output_sram_model::random_bits(8) | 8'h80,
                1 + output_sram_model::random_bits(2));
            repeat (24) write_burst(1, output_sram_model::random_bits(8) | 8'h80,
                1 + output_sram_model::random_bits(2));
        join
        wait_idle();
        node = output_sram_model::random_bits(8);
        fork
            write_burst(0, node, 4);
            write_burst(1, node ^ 8'h40, 4); // Same bank, another row.
            begin
                @(negedge clk);
                compare_value("$countones(vertex_wr_ready)", $countones(vertex_wr_ready), 1);
                win = vertex_wr_ready[0] ? 0 : 1;
                forever begin
                    compare_value($sformatf("vertex_wr_ready[%0d]", 1 - win),
                        vertex_wr_ready[1 - win], 0);
                    if (vertex_wr_ready[win] && vertex_wr_last[win]) break;
                    @(negedge clk);
                end
            end
        join
        read_node(0, node);
        read_node(1, node ^ 8'h40);
        wait_idle();
        // Nothing else is active, so the grant falls in the cycle after the accept.
        read_node(0, output_sram_model::random_bits(8));
        repeat (2) begin
            @(negedge clk);
            compare_value("edge_resp_valid[0]", edge_resp_valid[0], 0);
        end
        @(negedge clk);
        compare_value("edge_resp_valid[0]", edge_resp_valid[0], 1);
        wait_idle();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* output_sram_subsystem.f */
logic/out_sram_pkg.sv
logic/arb_req_if.sv
logic/rr_arbiter.sv
logic/edge_read_port.sv
logic/vertex_write_port.sv
logic/output_bus_arbiter.sv
logic/output_sram_bank.sv
logic/output_sram_subsystem.sv
tests/output_sram_model.sv
tests/output_sram_tb.sv
